//--- files.f
verilog/excPkg.sv
verilog/pipeStage.sv
verilog/fetchUnit.sv
verilog/decodeStage.sv
verilog/exceptionHandler.sv
verilog/retireCredit.sv
verilog/excPipeTop.sv
testbench/instrMemModel.sv
testbench/tbExcPipe.sv

//--- run.sh
#!/bin/sh
# Build the testbench with Verilator and run it, a $fatal gives a nonzero status
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f files.f --top-module tbExcPipe -o simExcPipe
./obj_dir/simExcPipe

//--- testbench/tbExcPipe.sv
`timescale 1ns/1ns
`default_nettype none

module tbExcPipe;
  import excPkg::*;

  localparam int Credits   = RetireCredits;
  localparam int Timeout   = 400;  // Cycles per wait
  localparam int FaultAddr = 'h40;

  logic                 clk;
  logic                 rst;
  logic [31:0]          instrWord;
  logic                 fetchAbort;
  logic                 irq;
  logic                 fiq;
  logic                 irqEnable;
  logic                 fiqEnable;
  logic                 creditReturn = 1'b0;
  logic [AddrWidth-1:0] instrAddr;
  logic                 retireValid;
  retireRec_t           retireRec;
  logic                 excValid;
  excRec_t              excRec;

  logic [3:0]  specialOp;    // Memory model setup
  logic [31:0] specialAddr;
  logic        abortEnable;
  logic [31:0] abortAddr;
  logic        holdCredits;  // Consumer returns nothing
  logic        randomCredits;
  logic [31:0] rngState = 32'h79e3da49;
  string       curTest = "reset"; // Name shown by monitor checks

  int          cycle;        // Cycles since reset release
  int          received;     // Records seen by the negedge monitor
  int          returned;     // Credits sent by the consumer
  int          outstanding;  // Records the DUT still counts against us
  logic [31:0] retQ[$];
  int          retCyc[$];
  excRec_t     excQ[$];
  int          excCyc[$];
  int          excRetCount[$]; // Retires seen up to each record

  excPipeTop #(.AddrWidth(AddrWidth), .RetireCredits(Credits)) UUT (
    .clk(clk), .rst(rst), .instrWord(instrWord), .fetchAbort(fetchAbort),
    .irq(irq), .fiq(fiq), .irqEnable(irqEnable), .fiqEnable(fiqEnable),
    .creditReturn(creditReturn), .instrAddr(instrAddr), .retireValid(retireValid),
    .retireRec(retireRec), .excValid(excValid), .excRec(excRec)
  );

  instrMemModel mem (
    .addr(instrAddr), .specialOp(specialOp), .specialAddr(specialAddr),
    .abortEnable(abortEnable), .abortAddr(abortAddr),
    .instrWord(instrWord), .fetchAbort(fetchAbort)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Word the memory model returns at an address
  function automatic logic [31:0] expectedWord(input logic [31:0] addr);
    logic [3:0] op;
    op = (addr == specialAddr) ? specialOp : 4'h0;
    return {op, addr[27:0] ^ {addr[31:28], 24'hc3a95e}};
  endfunction

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic expectEq(input string testName, input string what,
                          input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      failRun($sformatf("Fail %s: %s expected %0h actual %0h",
                        testName, what, expected, actual));
    end
  endtask

  // Outputs sampled mid cycle away from the driving edge
  always @(negedge clk) begin
    if (rst) begin
      cycle       = 0;
      received    = 0;
      outstanding = 0;
      retQ.delete();
      retCyc.delete();
      excQ.delete();
      excCyc.delete();
      excRetCount.delete();
    end else begin
      if (retireValid) begin
        retQ.push_back(retireRec.pc);
        retCyc.push_back(cycle);
        expectEq(curTest, "retired instr", expectedWord(retireRec.pc), retireRec.instr);
        received++;
        outstanding++;
        if (outstanding > Credits) begin
          failRun("Retire port sent a record without a free credit");
        end
      end
      if (creditReturn) outstanding--; // Counted by the DUT at the next edge
      if (excValid) begin
        excQ.push_back(excRec);
        excCyc.push_back(cycle);
        excRetCount.push_back(retQ.size());
      end
      cycle++;
    end
  end

  // Consumer hands back one credit per record it has taken
  always @(posedge clk) begin
    rngState <= xorshift(rngState);
    if (rst) begin
      creditReturn <= 1'b0;
      returned     <= 0;
    end else if (!holdCredits && received > returned && (!randomCredits || rngState[7])) begin
      creditReturn <= 1'b1;
      returned     <= returned + 1;
    end else begin
      creditReturn <= 1'b0;
    end
  end

  task automatic waitRetires(input string testName, input int n);
    int t;
    t = 0;
    while (retQ.size() < n) begin
      @(posedge clk);
      t++;
      if (t > Timeout) begin
        failRun($sformatf("%s: timed out waiting for %0d retired instructions", testName, n));
      end
    end
  endtask

  task automatic waitExc(input string testName, input int n);
    int t;
    t = 0;
    while (excQ.size() < n) begin
      @(posedge clk);
      t++;
      if (t > Timeout) failRun($sformatf("%s: timed out waiting for an exception", testName));
    end
  endtask

  // Returns on the edge where rst falls, which starts cycle 0
  task automatic resetDut(input logic [3:0] op, input logic [31:0] opAddr,
                          input logic abortOn, input logic [31:0] abortAt);
    @(posedge clk);
    rst           <= 1'b1;
    irq           <= 1'b0;
    fiq           <= 1'b0;
    irqEnable     <= 1'b0;
    fiqEnable     <= 1'b0;
    holdCredits   <= 1'b0;
    randomCredits <= 1'b0;
    specialOp     <= op;
    specialAddr   <= opAddr;
    abortEnable   <= abortOn;
    abortAddr     <= abortAt;
    repeat (10) @(posedge clk);
    rst <= 1'b0;
  endtask

  task automatic checkStraight(input string testName, input int n);
    int i;
    for (i = 0; i < n; i++) expectEq(testName, "retired pc", i * 4, retQ[i]);
  endtask

  task automatic testStraight();
    resetDut(4'h0, 0, 1'b0, 0);
    curTest = "straight";
    waitRetires("straight", 16);
    expectEq("straight", "first retire cycle", 4, retCyc[0]); // Fetched in cycle 0, in W at 4
    checkStraight("straight", 16);
    expectEq("straight", "exception count", 0, excQ.size());
  endtask

  // Fault at FaultAddr followed by the vector stream
  task automatic testFault(input string testName, input logic [3:0] op, input logic abortOn,
                           input logic [31:0] vec, input excCause_t cause,
                           input logic [31:0] linkOffset, input int excStage);
    int n;
    int j;
    n = FaultAddr / 4;
    resetDut(op, FaultAddr, abortOn, FaultAddr);
    curTest = testName;
    waitRetires(testName, n + 3);
    expectEq(testName, "exception count", 1, excQ.size());
    expectEq(testName, "cause", 32'(cause), 32'(excQ[0].cause));
    expectEq(testName, "link", FaultAddr + linkOffset, excQ[0].linkAddr);
    expectEq(testName, "exception cycle", n + excStage, excCyc[0]);
    checkStraight(testName, n);
    for (j = 0; j < 3; j++) expectEq(testName, "vector pc", vec + 32'(j * 4), retQ[n + j]);
  endtask

  task automatic testInterrupt(input string testName, input logic withFiq,
                               input logic [31:0] vec, input excCause_t cause);
    int k;
    resetDut(4'h0, 0, 1'b0, 0);
    curTest = testName;
    repeat (20) @(posedge clk);
    irq <= 1'b1;
    fiq <= withFiq;
    repeat (20) @(posedge clk);
    expectEq(testName, "records while masked", 0, excQ.size());
    irqEnable <= 1'b1;
    fiqEnable <= withFiq;
    waitExc(testName, 1);
    irq <= 1'b0; // Dropped right after entry so nothing nests
    fiq <= 1'b0;
    k = excRetCount[0];
    waitRetires(testName, k + 3);
    expectEq(testName, "exception count", 1, excQ.size());
    expectEq(testName, "cause", 32'(cause), 32'(excQ[0].cause));
    checkStraight(testName, k);
    expectEq(testName, "link", retQ[k - 1] + 32'd8, excQ[0].linkAddr); // P + 4
    expectEq(testName, "vector pc", vec, retQ[k]);
    expectEq(testName, "vector pc", vec + 32'd4, retQ[k + 1]);
  endtask

  task automatic testBackPressure();
    resetDut(4'h0, 0, 1'b0, 0);
    curTest = "backpressure";
    holdCredits   <= 1'b1;
    randomCredits <= 1'b1;
    repeat (30) @(posedge clk);
    expectEq("backpressure", "records without credit", Credits, retQ.size());
    holdCredits <= 1'b0;
    waitRetires("backpressure", 24);
    checkStraight("backpressure", 24);
    expectEq("backpressure", "exception count", 0, excQ.size());
  endtask

  initial begin
    rst           = 1'b1;
    irq           = 1'b0;
    fiq           = 1'b0;
    irqEnable     = 1'b0;
    fiqEnable     = 1'b0;
    specialOp     = 4'h0;
    specialAddr   = 32'd0;
    abortEnable   = 1'b0;
    abortAddr     = 32'd0;
    holdCredits   = 1'b0;
    randomCredits = 1'b0;
    testStraight();
    testFault("undef", OpUndef, 1'b0, VecUndef, ExcUndef, 32'd4, 2);
    testFault("swi", OpSwi, 1'b0, VecSwi, ExcSwi, 32'd4, 2);
    testFault("prefetch", OpNormal, 1'b1, VecPrefetch, ExcPrefetch, 32'd4, 2);
    testFault("data", OpLoadFault, 1'b0, VecData, ExcData, 32'd8, 4); // Record in 2nd cycle
    testInterrupt("irq", 1'b0, VecIrq, ExcIrq);
    testInterrupt("fiq", 1'b1, VecFiq, ExcFiq);
    testBackPressure();
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/instrMemModel.sv
`timescale 1ns/1ns
`default_nettype none

// Combinational instruction port
// Every word is normal except one programmable special word, one address may abort
module instrMemModel (
  input  logic [31:0] addr,
  input  logic [3:0]  specialOp,   // Class forced at specialAddr
  input  logic [31:0] specialAddr,
  input  logic        abortEnable,
  input  logic [31:0] abortAddr,
  output logic [31:0] instrWord,
  output logic        fetchAbort
);

  logic [27:0] fill; // Body bits of the word

  // Top nibble folded back in, so the fill depends on every address bit
  assign fill = addr[27:0] ^ {addr[31:28], 24'hc3a95e};

  always_comb begin
    if (addr == specialAddr) begin
      instrWord = {specialOp, fill};
    end else begin
      instrWord = {4'h0, fill}; // Normal class
    end
  end

  assign fetchAbort = abortEnable & (addr == abortAddr); // Same cycle as the word

endmodule

`default_nettype wire

//--- verilog/excPipeTop.sv
`timescale 1ns/1ns
`default_nettype none

module excPipeTop #(
  parameter int AddrWidth     = excPkg::AddrWidth,
  parameter int RetireCredits = excPkg::RetireCredits
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [31:0]                  instrWord,
  input  logic                         fetchAbort,
  input  logic                         irq,
  input  logic                         fiq,
  input  logic                         irqEnable,
  input  logic                         fiqEnable,
  input  logic                         creditReturn,
  output logic [excPkg::AddrWidth-1:0] instrAddr,
  output logic                         retireValid,
  output excPkg::retireRec_t           retireRec,
  output logic                         excValid,
  output excPkg::excRec_t              excRec
);
  import excPkg::*;

  fetchTok_t tokF;
  fetchTok_t tokD;
  execTok_t  tokDec;   // Decoded D token, input of stage E
  execTok_t  tokE;
  execTok_t  tokM;
  execTok_t  tokW;

  logic [AddrWidth-1:0] pcD;
  logic [AddrWidth-1:0] linkAddr;
  logic [6:0]           vectorOneHot;
  logic [1:0]           pcInSelect;
  excCause_t            excCause;
  logic pipelineClearF, pipelineClearD, pipelineClearM;
  logic flushD, flushE, flushM, flushW;
  logic stallD, stallF, savePc, globalStall;
  logic undefE, swiE, prefetchAbortE, loadFaultM;

  // Handler only sees E and M while the pipe moves, one event per token
  assign undefE         = tokE.undef & ~globalStall;
  assign swiE           = tokE.swi & ~globalStall;
  assign prefetchAbortE = tokE.prefetchAbort & ~globalStall;
  assign loadFaultM     = tokM.loadFault & ~globalStall;
  assign pipelineClearM = tokM.clearMarker & ~globalStall;
  assign stallF         = globalStall | stallD; // F waits whenever D holds

  fetchUnit #(.AddrWidth(AddrWidth)) fetch (
    .clk(clk), .rst(rst), .stall(stallF), .pcInSelect(pcInSelect),
    .vectorOneHot(vectorOneHot), .savePc(savePc), .pipelineClearF(pipelineClearF),
    .pcD(pcD), .instrWord(instrWord), .fetchAbort(fetchAbort),
    .instrAddr(instrAddr), .fetchTok(tokF), .linkAddr(linkAddr)
  );

  pipeStage #(.tok_t(fetchTok_t)) stageD (
    .clk(clk), .rst(rst), .stall(stallF), .flush(flushD), .d(tokF), .q(tokD)
  );

  decodeStage decode (
    .tokD(tokD), .tokE(tokDec), .pcD(pcD), .pipelineClearD(pipelineClearD)
  );

  pipeStage #(.tok_t(execTok_t)) stageE (
    .clk(clk), .rst(rst), .stall(globalStall), .flush(flushE), .d(tokDec), .q(tokE)
  );

  pipeStage #(.tok_t(execTok_t)) stageM (
    .clk(clk), .rst(rst), .stall(globalStall), .flush(flushM), .d(tokE), .q(tokM)
  );

  pipeStage #(.tok_t(execTok_t)) stageW (
    .clk(clk), .rst(rst), .stall(globalStall), .flush(flushW), .d(tokM), .q(tokW)
  );

  exceptionHandler handler (
    .clk(clk), .rst(rst), .undefE(undefE), .swiE(swiE),
    .prefetchAbortE(prefetchAbortE), .loadFaultM(loadFaultM),
    .irq(irq), .fiq(fiq), .irqEnable(irqEnable), .fiqEnable(fiqEnable),
    .pipelineClearD(pipelineClearD), .pipelineClearM(pipelineClearM),
    .pipelineClearF(pipelineClearF), .flushD(flushD), .flushE(flushE),
    .flushM(flushM), .flushW(flushW), .stallD(stallD), .savePc(savePc),
    .vectorOneHot(vectorOneHot), .pcInSelect(pcInSelect),
    .excValid(excValid), .excCause(excCause)
  );

  retireCredit #(.RetireCredits(RetireCredits)) retire (
    .clk(clk), .rst(rst), .tokW(tokW), .creditReturn(creditReturn),
    .globalStall(globalStall), .retireValid(retireValid), .retireRec(retireRec)
  );

  always_comb begin
    excRec.cause    = excCause;
    excRec.linkAddr = linkAddr; // Valid with excValid only
  end

endmodule

`default_nettype wire

//--- verilog/retireCredit.sv
`timescale 1ns/1ns
`default_nettype none

module retireCredit #(
  parameter int RetireCredits = excPkg::RetireCredits
) (
  input  logic               clk,
  input  logic               rst,
  input  excPkg::execTok_t   tokW,
  input  logic               creditReturn,
  output logic               globalStall,
  output logic               retireValid,
  output excPkg::retireRec_t retireRec
);

  localparam int CountWidth = $clog2(RetireCredits + 1);

  logic [CountWidth-1:0] credits;   // Records the consumer can still take
  logic                  hasCredit;
  logic                  wantRetire; // Real instruction sitting in W

  assign hasCredit   = credits != '0;
  assign wantRetire  = tokW.valid & ~tokW.clearMarker;
  assign retireValid = wantRetire & hasCredit;
  assign globalStall = wantRetire & ~hasCredit; // Freeze, W keeps its token

  always_comb begin
    retireRec.pc    = tokW.pc;
    retireRec.instr = tokW.instr;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CountWidth'(RetireCredits);
    end else begin
      case ({retireValid, creditReturn})
        2'b10:   credits <= credits - CountWidth'(1);
        2'b01:   credits <= credits + CountWidth'(1);
        default: credits <= credits; // Both or neither
      endcase
    end
  end

endmodule

`default_nettype wire

//--- verilog/exceptionHandler.sv
`timescale 1ns/1ns
`default_nettype none

module exceptionHandler (
  input  logic              clk,
  input  logic              rst,
  input  logic              undefE,
  input  logic              swiE,
  input  logic              prefetchAbortE,
  input  logic              loadFaultM,
  input  logic              irq,
  input  logic              fiq,
  input  logic              irqEnable,
  input  logic              fiqEnable,
  input  logic              pipelineClearD,
  input  logic              pipelineClearM,
  output logic              pipelineClearF,
  output logic              flushD,
  output logic              flushE,
  output logic              flushM,
  output logic              flushW,
  output logic              stallD,
  output logic              savePc,
  output logic [6:0]        vectorOneHot,
  output logic [1:0]        pcInSelect,
  output logic              excValid,
  output excPkg::excCause_t excCause
);
  import excPkg::*;

  logic dataAbortCycle2; // Record cycle of a data abort
  logic irqEnSync;
  logic fiqEnSync;
  logic dataAbortAny;
  logic excE;            // Exception caught in E and not overridden
  logic clearReady;      // First marker in M, P marker behind it in D
  logic irqAssert;
  logic fiqAssert;

  always_ff @(posedge clk) begin
    if (rst) begin
      dataAbortCycle2 <= 1'b0;
      irqEnSync       <= 1'b0;
      fiqEnSync       <= 1'b0;
    end else begin
      dataAbortCycle2 <= loadFaultM; // M is flushed, so never two in a row
      irqEnSync       <= irqEnable;
      fiqEnSync       <= fiqEnable;
    end
  end

  assign dataAbortAny = loadFaultM | dataAbortCycle2;
  assign excE         = (undefE | swiE | prefetchAbortE) & ~dataAbortAny;
  assign clearReady   = pipelineClearM & pipelineClearD;

  always_comb begin
    irqAssert      = 1'b0;
    fiqAssert      = 1'b0;
    pipelineClearF = 1'b0;
    {flushD, flushE, flushM, flushW} = 4'b0000;
    stallD         = 1'b0;
    if (dataAbortAny) begin
      // Fault and younger work die, D keeps pc + 8 for the second cycle
      {flushD, flushE, flushM, flushW} = 4'b1111;
      stallD = loadFaultM;
    end else if (excE) begin
      // Fault stays out of M, older work in M still retires
      {flushD, flushE, flushM, flushW} = 4'b1110;
    end else if (fiq & fiqEnSync) begin
      fiqAssert      = clearReady;
      pipelineClearF = ~clearReady;             // Keep sending markers
      {flushD, flushE, flushM, flushW} = {4{clearReady}}; // Drop the markers
    end else if (irq & irqEnSync) begin
      irqAssert      = clearReady;              // Same drain as FIQ
      pipelineClearF = ~clearReady;
      {flushD, flushE, flushM, flushW} = {4{clearReady}};
    end
  end

  assign vectorOneHot = {fiqAssert, irqAssert, dataAbortCycle2,
                         prefetchAbortE & excE, swiE & excE, undefE & excE, rst};
  assign savePc   = |vectorOneHot;
  assign excValid = |vectorOneHot[6:1]; // Reset is not reported

  always_comb begin
    if (irqAssert | fiqAssert) begin
      pcInSelect = 2'b10;   // P + 4
    end else if (excE | dataAbortCycle2) begin
      pcInSelect = 2'b01;   // D pc as is
    end else begin
      pcInSelect = 2'b00;
    end
  end

  always_comb begin
    if (vectorOneHot[6]) excCause = ExcFiq;
    else if (vectorOneHot[5]) excCause = ExcIrq;
    else if (vectorOneHot[4]) excCause = ExcData;
    else if (vectorOneHot[3]) excCause = ExcPrefetch;
    else if (vectorOneHot[2]) excCause = ExcSwi;
    else excCause = ExcUndef;
  end

endmodule

`default_nettype wire

//--- verilog/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
  input  excPkg::fetchTok_t            tokD,
  output excPkg::execTok_t             tokE,
  output logic [excPkg::AddrWidth-1:0] pcD,
  output logic                         pipelineClearD
);
  import excPkg::*;

  opClass_t opClass;
  logic     live;    // Real instruction with a usable word

  assign opClass = opClass_t'(tokD.instr[31:28]);
  assign live    = tokD.valid & ~tokD.prefetchAbort; // Aborted word is garbage

  always_comb begin
    tokE.valid         = tokD.valid;
    tokE.pc            = tokD.pc;
    tokE.instr         = tokD.instr;
    tokE.undef         = 1'b0;
    tokE.swi           = 1'b0;
    tokE.loadFault     = 1'b0;
    tokE.prefetchAbort = tokD.prefetchAbort;
    tokE.clearMarker   = tokD.clearMarker;
    // At most one cause flag per token
    if (live) begin
      case (opClass)
        OpUndef:     tokE.undef     = 1'b1;
        OpSwi:       tokE.swi       = 1'b1;
        OpLoadFault: tokE.loadFault = 1'b1;
        default:     ;  // Normal
      endcase
    end
  end

  // Seen by the handler for link and drain control
  assign pcD            = tokD.pc;
  assign pipelineClearD = tokD.clearMarker;

endmodule

`default_nettype wire

//--- verilog/fetchUnit.sv
`timescale 1ns/1ns
`default_nettype none

module fetchUnit #(
  parameter int AddrWidth = excPkg::AddrWidth
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         stall,
  input  logic [1:0]                   pcInSelect,
  input  logic [6:0]                   vectorOneHot,
  input  logic                         savePc,
  input  logic                         pipelineClearF,
  input  logic [excPkg::AddrWidth-1:0] pcD,
  input  logic [31:0]                  instrWord,
  input  logic                         fetchAbort,
  output logic [excPkg::AddrWidth-1:0] instrAddr,
  output excPkg::fetchTok_t            fetchTok,
  output logic [excPkg::AddrWidth-1:0] linkAddr
);
  import excPkg::*;

  logic [AddrWidth-1:0] pc;      // Address fetched this cycle
  logic [AddrWidth-1:0] vecAddr; // Vector chosen by the handler

  // Highest priority cause first, bit 0 is the reset request
  always_comb begin
    vecAddr = '0;
    if (vectorOneHot[6]) vecAddr = AddrWidth'(VecFiq);
    else if (vectorOneHot[5]) vecAddr = AddrWidth'(VecIrq);
    else if (vectorOneHot[4]) vecAddr = AddrWidth'(VecData);
    else if (vectorOneHot[3]) vecAddr = AddrWidth'(VecPrefetch);
    else if (vectorOneHot[2]) vecAddr = AddrWidth'(VecSwi);
    else if (vectorOneHot[1]) vecAddr = AddrWidth'(VecUndef);
    else if (vectorOneHot[0]) vecAddr = '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (savePc) begin
      pc <= vecAddr;                 // Redirect to the vector table
    end else if (stall | pipelineClearF) begin
      pc <= pc;                      // Held PC becomes P for a clear marker
    end else begin
      pc <= pc + AddrWidth'(4);
    end
  end

  assign instrAddr = pc;

  // While draining for an interrupt only markers leave F
  always_comb begin
    fetchTok.valid         = ~pipelineClearF;
    fetchTok.pc            = pc;
    fetchTok.instr         = pipelineClearF ? 32'd0 : instrWord; // Marker has no opcode
    fetchTok.prefetchAbort = fetchAbort & ~pipelineClearF;
    fetchTok.clearMarker   = pipelineClearF;
  end

  // Link address from the D pc
  always_comb begin
    case (pcInSelect)
      2'b10:   linkAddr = pcD + 'd4; // Interrupt, D holds P
      default: linkAddr = pcD;       // D already one or two words ahead
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/pipeStage.sv
`timescale 1ns/1ns
`default_nettype none

// One pipeline register between two stages
// Stall holds the token, flush loads a bubble, stall wins over flush
module pipeStage #(
  parameter type tok_t = logic
) (
  input  logic clk,
  input  logic rst,
  input  logic stall,
  input  logic flush,
  input  tok_t d,
  output tok_t q
);

  always_ff @(posedge clk) begin
    if (rst) begin
      q <= '0;           // All zero means invalid
    end else if (stall) begin
      q <= q;            // Hold for this cycle
    end else if (flush) begin
      q <= '0;           // Bubble
    end else begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- verilog/excPkg.sv
`default_nettype none

package excPkg;

  localparam int AddrWidth     = 32; // One word of instruction address
  localparam int RetireCredits = 4;  // Default depth of the retire consumer

  // Instruction class in bits 31..28, other codes decode as normal
  typedef enum logic [3:0] {
    OpNormal    = 4'h0,
    OpUndef     = 4'h1,
    OpSwi       = 4'h2,
    OpLoadFault = 4'h3  // Load that aborts once it reaches M
  } opClass_t;

  typedef enum logic [2:0] {
    ExcUndef    = 3'd0,
    ExcSwi      = 3'd1,
    ExcPrefetch = 3'd2,
    ExcData     = 3'd3,
    ExcIrq      = 3'd4,
    ExcFiq      = 3'd5
  } excCause_t;

  // F to D token
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] pc;
    logic [31:0]          instr;
    logic                 prefetchAbort; // Fetch port flagged this word
    logic                 clearMarker;   // Interrupt drain marker, pc holds P
  } fetchTok_t;

  // D to E, E to M and M to W token
  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] pc;
    logic [31:0]          instr;         // Kept so that W can report it
    logic                 undef;
    logic                 swi;
    logic                 loadFault;     // Acted on in M only
    logic                 prefetchAbort;
    logic                 clearMarker;
  } execTok_t;

  typedef struct packed {
    logic [AddrWidth-1:0] pc;
    logic [31:0]          instr;
  } retireRec_t;

  typedef struct packed {
    excCause_t            cause;
    logic [AddrWidth-1:0] linkAddr;
  } excRec_t;

  // ARM vector table
  localparam logic [AddrWidth-1:0] VecUndef    = 'h04;
  localparam logic [AddrWidth-1:0] VecSwi      = 'h08;
  localparam logic [AddrWidth-1:0] VecPrefetch = 'h0C;
  localparam logic [AddrWidth-1:0] VecData     = 'h10;
  localparam logic [AddrWidth-1:0] VecIrq      = 'h18;
  localparam logic [AddrWidth-1:0] VecFiq      = 'h1C;

endpackage

`default_nettype wire
